// ==== hw/reg_write_if.sv ====
/* one register write path
   enable strobe, target register, value and int/float file select */
interface reg_write_if;
   import regmgr_pkg::*;

   logic                  enable;
   logic [REG_ADDR_W-1:0] addr;
   logic [REG_DATA_W-1:0] data;
   logic                  float;  // high selects the float file

   // producer side
   modport src (
      output enable,
      output addr,
      output data,
      output float
   );

   // consumer side
   modport snk (
      input enable,
      input addr,
      input data,
      input float
   );

endinterface

// ==== hw/register_file.sv ====
/* register array, NUM_REGS words
   two asynchronous reads, one clocked write, old data on read during write */
module register_file (
   input  logic                              clk,
   input  logic [regmgr_pkg::REG_ADDR_W-1:0] read_addr1,
   input  logic [regmgr_pkg::REG_ADDR_W-1:0] read_addr2,
   output logic [regmgr_pkg::REG_DATA_W-1:0] read_data1,
   output logic [regmgr_pkg::REG_DATA_W-1:0] read_data2,
   input  logic                              write_enable,
   input  logic [regmgr_pkg::REG_ADDR_W-1:0] write_addr,
   input  logic [regmgr_pkg::REG_DATA_W-1:0] write_data
);
   import regmgr_pkg::*;

   logic [REG_DATA_W-1:0] regs [NUM_REGS];

   // write lands at the edge, so a same-cycle read still sees the old word
   always_ff @(posedge clk) begin
      if (write_enable) begin
         regs[write_addr] <= write_data;
      end
   end

   assign read_data1 = regs[read_addr1];
   assign read_data2 = regs[read_addr2];

endmodule

// ==== hw/register_forwarding.sv ====
/* same-cycle forwarding
   overrides registered read data with a matching write-back of this cycle */
module register_forwarding (
   input  logic [regmgr_pkg::REG_ADDR_W-1:0] addr,
   input  logic                              float,
   input  logic [regmgr_pkg::REG_DATA_W-1:0] data,
   reg_write_if.snk                          misc,
   reg_write_if.snk                          alu,
   reg_write_if.snk                          mem,
   reg_write_if.snk                          fpu,
   output logic [regmgr_pkg::REG_DATA_W-1:0] forward_data
);
   import regmgr_pkg::*;

   function automatic logic match(
      input logic                  en,
      input logic [REG_ADDR_W-1:0] wr_addr,
      input logic                  wr_float
   );
      return en && (wr_addr == addr) && (wr_float == float);
   endfunction

   logic hit_misc;
   logic hit_alu;
   logic hit_mem;
   logic hit_fpu;

   assign hit_misc = match(misc.enable, misc.addr, misc.float);
   assign hit_alu  = match(alu.enable, alu.addr, alu.float);
   assign hit_mem  = match(mem.enable, mem.addr, mem.float);
   assign hit_fpu  = match(fpu.enable, fpu.addr, fpu.float);

   // later matches override earlier ones, fpu is the youngest
   always_comb begin
      forward_data = data;
      if (hit_misc) begin
         forward_data = misc.data;
      end
      if (hit_alu) begin
         forward_data = alu.data;  // alu and misc never collide
      end
      if (hit_mem) begin
         forward_data = mem.data;
      end
      if (hit_fpu) begin
         forward_data = fpu.data;
      end
   end

endmodule

// ==== hw/register_manager.sv ====
/* register manager top
   merges four write-back ports into int/float files with bypassed reads */
module register_manager (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              write_enable_misc,
   input  logic [regmgr_pkg::REG_ADDR_W-1:0] write_addr_misc,
   input  logic [regmgr_pkg::REG_DATA_W-1:0] write_data_misc,
   input  logic                              write_float_misc,
   input  logic                              write_enable_alu,
   input  logic [regmgr_pkg::REG_ADDR_W-1:0] write_addr_alu,
   input  logic [regmgr_pkg::REG_DATA_W-1:0] write_data_alu,
   input  logic                              write_float_alu,
   input  logic                              write_enable_mem,
   input  logic [regmgr_pkg::REG_ADDR_W-1:0] write_addr_mem,
   input  logic [regmgr_pkg::REG_DATA_W-1:0] write_data_mem,
   input  logic                              write_float_mem,
   input  logic                              write_enable_fpu,
   input  logic [regmgr_pkg::REG_ADDR_W-1:0] write_addr_fpu,
   input  logic [regmgr_pkg::REG_DATA_W-1:0] write_data_fpu,
   input  logic                              write_float_fpu,
   input  logic [regmgr_pkg::REG_ADDR_W-1:0] rs_addr,
   input  logic [regmgr_pkg::REG_ADDR_W-1:0] rt_addr,
   input  logic                              rs_float,
   input  logic                              rt_float,
   output logic [regmgr_pkg::REG_DATA_W-1:0] rs_data,
   output logic [regmgr_pkg::REG_DATA_W-1:0] rt_data
);
   import regmgr_pkg::*;

   reg_write_if wb_misc ();
   reg_write_if wb_alu ();
   reg_write_if wb_mem ();
   reg_write_if wb_fpu ();

   reg_write_if stage2 ();
   reg_write_if stage2_clk ();
   reg_write_if stage1 ();
   reg_write_if stage1_clk ();
   reg_write_if stage0 ();

   logic                  int_write_enable;
   logic                  float_write_enable;
   logic [REG_DATA_W-1:0] int_rs_data;
   logic [REG_DATA_W-1:0] int_rt_data;
   logic [REG_DATA_W-1:0] float_rs_data;
   logic [REG_DATA_W-1:0] float_rt_data;
   logic [REG_DATA_W-1:0] raw_rs_data;
   logic [REG_DATA_W-1:0] raw_rt_data;
   logic [REG_DATA_W-1:0] rs_data_q;
   logic [REG_DATA_W-1:0] rt_data_q;
   logic [REG_ADDR_W-1:0] rs_addr_q;
   logic [REG_ADDR_W-1:0] rt_addr_q;
   logic                  rs_float_q;
   logic                  rt_float_q;

   assign wb_misc.enable = write_enable_misc;
   assign wb_misc.addr   = write_addr_misc;
   assign wb_misc.data   = write_data_misc;
   assign wb_misc.float  = write_float_misc;
   assign wb_alu.enable  = write_enable_alu;
   assign wb_alu.addr    = write_addr_alu;
   assign wb_alu.data    = write_data_alu;
   assign wb_alu.float   = write_float_alu;
   assign wb_mem.enable  = write_enable_mem;
   assign wb_mem.addr    = write_addr_mem;
   assign wb_mem.data    = write_data_mem;
   assign wb_mem.float   = write_float_mem;
   assign wb_fpu.enable  = write_enable_fpu;
   assign wb_fpu.addr    = write_addr_fpu;
   assign wb_fpu.data    = write_data_fpu;
   assign wb_fpu.float   = write_float_fpu;

   // write queue, alu/misc two cycles out, mem one, fpu retires at once
   register_queue_block queue2 (.clk, .rst_n, .side(wb_alu), .up(wb_misc), .down(stage2));
   register_queue_block queue1 (.clk, .rst_n, .side(wb_mem), .up(stage2_clk), .down(stage1));
   register_queue_block queue0 (.clk, .rst_n, .side(wb_fpu), .up(stage1_clk), .down(stage0));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         stage2_clk.enable <= 1'b0;
         stage1_clk.enable <= 1'b0;
      end else begin
         stage2_clk.enable <= stage2.enable;
         stage1_clk.enable <= stage1.enable;
      end
   end

   always_ff @(posedge clk) begin
      stage2_clk.addr  <= stage2.addr;
      stage2_clk.data  <= stage2.data;
      stage2_clk.float <= stage2.float;
      stage1_clk.addr  <= stage1.addr;
      stage1_clk.data  <= stage1.data;
      stage1_clk.float <= stage1.float;
   end

   // steer the retiring write by its float flag
   assign int_write_enable   = stage0.enable && !stage0.float;
   assign float_write_enable = stage0.enable && stage0.float;

   register_file int_register (
      .clk, .read_addr1(rs_addr), .read_addr2(rt_addr),
      .read_data1(int_rs_data), .read_data2(int_rt_data),
      .write_enable(int_write_enable), .write_addr(stage0.addr), .write_data(stage0.data)
   );

   register_file float_register (
      .clk, .read_addr1(rs_addr), .read_addr2(rt_addr),
      .read_data1(float_rs_data), .read_data2(float_rt_data),
      .write_enable(float_write_enable), .write_addr(stage0.addr), .write_data(stage0.data)
   );

   register_read_port rs_read (
      .addr(rs_addr), .float(rs_float), .stage0, .stage1, .stage2,
      .int_data(int_rs_data), .float_data(float_rs_data), .data(raw_rs_data)
   );

   register_read_port rt_read (
      .addr(rt_addr), .float(rt_float), .stage0, .stage1, .stage2,
      .int_data(int_rt_data), .float_data(float_rt_data), .data(raw_rt_data)
   );

   // one cycle read latency
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rs_data_q  <= '0;
         rt_data_q  <= '0;
         rs_addr_q  <= '0;
         rt_addr_q  <= '0;
         rs_float_q <= 1'b0;
         rt_float_q <= 1'b0;
      end else begin
         rs_data_q  <= raw_rs_data;
         rt_data_q  <= raw_rt_data;
         rs_addr_q  <= rs_addr;
         rt_addr_q  <= rt_addr;
         rs_float_q <= rs_float;
         rt_float_q <= rt_float;
      end
   end

   register_forwarding rs_forward (
      .addr(rs_addr_q), .float(rs_float_q), .data(rs_data_q),
      .misc(wb_misc), .alu(wb_alu), .mem(wb_mem), .fpu(wb_fpu), .forward_data(rs_data)
   );

   register_forwarding rt_forward (
      .addr(rt_addr_q), .float(rt_float_q), .data(rt_data_q),
      .misc(wb_misc), .alu(wb_alu), .mem(wb_mem), .fpu(wb_fpu), .forward_data(rt_data)
   );

   a_one_file : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(int_write_enable && float_write_enable)
   ) else $error("write enable high for both register files");

   a_queue_empty : assert property (
      @(posedge clk) !rst_n |=> !stage2_clk.enable && !stage1_clk.enable
   ) else $error("queue stage enabled after reset");

endmodule

// ==== hw/register_queue_block.sv ====
/* write queue merge point
   passes the side write when enabled, otherwise the upstream write */
module register_queue_block (
   input  logic     clk,
   input  logic     rst_n,
   reg_write_if.snk side,
   reg_write_if.snk up,
   reg_write_if.src down
);

   always_comb begin
      if (side.enable) begin
         down.enable = 1'b1;
         down.addr   = side.addr;
         down.data   = side.data;
         down.float  = side.float;
      end else begin
         // upstream keeps moving toward the files
         down.enable = up.enable;
         down.addr   = up.addr;
         down.data   = up.data;
         down.float  = up.float;
      end
   end

   // the issue side must keep two writes out of one stage
   a_no_collision : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(side.enable && up.enable)
   ) else $error("queue collision, side and upstream write in one stage");

endmodule

// ==== hw/register_read_port.sv ====
/* read port bypass
   picks the newest pending queue write for a read, else the file data */
module register_read_port (
   input  logic [regmgr_pkg::REG_ADDR_W-1:0] addr,
   input  logic                              float,
   reg_write_if.snk                          stage0,
   reg_write_if.snk                          stage1,
   reg_write_if.snk                          stage2,
   input  logic [regmgr_pkg::REG_DATA_W-1:0] int_data,
   input  logic [regmgr_pkg::REG_DATA_W-1:0] float_data,
   output logic [regmgr_pkg::REG_DATA_W-1:0] data
);
   import regmgr_pkg::*;

   logic        hit0;
   logic        hit1;
   logic        hit2;
   bypass_src_e src;

   // a hit needs the same register in the same file
   assign hit0 = stage0.enable && (stage0.addr == addr) && (stage0.float == float);
   assign hit1 = stage1.enable && (stage1.addr == addr) && (stage1.float == float);
   assign hit2 = stage2.enable && (stage2.addr == addr) && (stage2.float == float);

   // stage 0 ranks first
   always_comb begin
      if (hit0) begin
         src = SRC_STAGE0;
      end else if (hit1) begin
         src = SRC_STAGE1;
      end else if (hit2) begin
         src = SRC_STAGE2;
      end else begin
         src = SRC_FILE;
      end
   end

   always_comb begin
      case (src)
         SRC_STAGE0: data = stage0.data;
         SRC_STAGE1: data = stage1.data;
         SRC_STAGE2: data = stage2.data;
         default: begin
            // no pending write, the file is current
            if (float) begin
               data = float_data;
            end else begin
               data = int_data;
            end
         end
      endcase
   end

endmodule

// ==== hw/regmgr_pkg.sv ====
/* register manager package
   ISA widths, register count and the read bypass source encoding */
package regmgr_pkg;

   // ISA sizes
   localparam int REG_ADDR_W = 5;
   localparam int REG_DATA_W = 32;
   localparam int NUM_REGS   = 32;  // per file, int and float alike

   // where a read takes its data from, in falling priority
   typedef enum logic [1:0] {
      SRC_STAGE0 = 2'd0,  // last queue stage, retiring this cycle
      SRC_STAGE1 = 2'd1,
      SRC_STAGE2 = 2'd2,  // first queue stage, alu/misc merge
      SRC_FILE   = 2'd3   // nothing pending, register file holds it
   } bypass_src_e;

endpackage

// ==== register_manager.f ====
hw/regmgr_pkg.sv
hw/reg_write_if.sv
hw/register_queue_block.sv
hw/register_file.sv
hw/register_read_port.sv
hw/register_forwarding.sv
hw/register_manager.sv
verif/register_manager_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the register manager testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module register_manager_tb -f register_manager.f -o register_manager_sim \
   && ./obj_dir/register_manager_sim > sim.log 2>&1 \
   || echo "CHECKS FAILED" >> sim.log

cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; } \
   || { echo "simulation passed"; exit 0; }

// ==== verif/register_manager_tb.sv ====
/* register manager testbench
   file model driven under the issue rule, read data checked by assertions */
module register_manager_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import regmgr_pkg::*;

   localparam int RESET_CYCLES  = 8;
   localparam int RANDOM_CYCLES = 400;
   // cycles per test, two drain cycles each
   localparam int FILL_LEN      = 3 * NUM_REGS + 2;
   localparam int BYPASS_LEN    = 3 * 4 + 2;
   localparam int FORWARD_LEN   = 4 * 5 + 2;
   localparam int SEPARATE_LEN  = 2 * 4 + 2;
   localparam int RANDOM_LEN    = RANDOM_CYCLES + 2;
   localparam int CYCLE_LIMIT   = RESET_CYCLES + 1 + FILL_LEN + BYPASS_LEN + FORWARD_LEN
                                  + SEPARATE_LEN + RANDOM_LEN + 100;

   // write port index, also program order inside one cycle
   localparam int P_MISC = 0;
   localparam int P_ALU  = 1;
   localparam int P_MEM  = 2;
   localparam int P_FPU  = 3;

   logic                  clk;
   logic                  rst_n;
   logic                  w_en   [4];
   logic [REG_ADDR_W-1:0] w_addr [4];
   logic [REG_DATA_W-1:0] w_data [4];
   logic                  w_fl   [4];
   logic [REG_ADDR_W-1:0] rs_addr;
   logic [REG_ADDR_W-1:0] rt_addr;
   logic                  rs_float;
   logic                  rt_float;
   logic [REG_DATA_W-1:0] rs_data;
   logic [REG_DATA_W-1:0] rt_data;

   // staged for the next cycle
   logic                  st_en   [4];
   logic [REG_ADDR_W-1:0] st_addr [4];
   logic [REG_DATA_W-1:0] st_data [4];
   logic                  st_fl   [4];
   logic                  rd_valid;
   logic                  rd_sep;
   logic [REG_ADDR_W-1:0] rd_rs_addr;
   logic [REG_ADDR_W-1:0] rd_rt_addr;
   logic                  rd_rs_float;
   logic                  rd_rt_float;

   // read presented in the cycle before
   logic                  prev_valid;
   logic                  prev_sep;
   logic [REG_ADDR_W-1:0] prev_rs_addr;
   logic [REG_ADDR_W-1:0] prev_rt_addr;
   logic                  prev_rs_float;
   logic                  prev_rt_float;

   logic                  check_rs;
   logic                  check_rt;
   logic                  check_sep;
   logic [REG_DATA_W-1:0] exp_rs;
   logic [REG_DATA_W-1:0] exp_rt;

   logic [REG_DATA_W-1:0] model [2][NUM_REGS];  // [float][addr]
   int                    busy_until [2][NUM_REGS];  // cycle the pending write retires
   logic                  am_prev;
   logic                  am_prev2;
   logic                  mem_prev;
   int                    cyc = 0;
   int                    cycle_count = 0;
   int                    checks = 0;
   int                    test_base = 0;
   int                    seed;
   int                    rs_errors = 0;
   int                    rt_errors = 0;
   int                    sep_errors = 0;

   register_manager uut (
      .clk, .rst_n,
      .write_enable_misc(w_en[P_MISC]), .write_addr_misc(w_addr[P_MISC]),
      .write_data_misc(w_data[P_MISC]), .write_float_misc(w_fl[P_MISC]),
      .write_enable_alu(w_en[P_ALU]), .write_addr_alu(w_addr[P_ALU]),
      .write_data_alu(w_data[P_ALU]), .write_float_alu(w_fl[P_ALU]),
      .write_enable_mem(w_en[P_MEM]), .write_addr_mem(w_addr[P_MEM]),
      .write_data_mem(w_data[P_MEM]), .write_float_mem(w_fl[P_MEM]),
      .write_enable_fpu(w_en[P_FPU]), .write_addr_fpu(w_addr[P_FPU]),
      .write_data_fpu(w_data[P_FPU]), .write_float_fpu(w_fl[P_FPU]),
      .rs_addr, .rt_addr, .rs_float, .rt_float, .rs_data, .rt_data
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > CYCLE_LIMIT) begin
         $display("timeout, run did not end within %0d cycles", CYCLE_LIMIT);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   a_rs_data : assert property (
      @(posedge clk) disable iff (!rst_n) !check_rs || rs_data == exp_rs
   ) else begin
      $display("ERR %0t rs_data expected %h actual %h", $time, $sampled(exp_rs),
               $sampled(rs_data));
      rs_errors++;
   end

   a_rt_data : assert property (
      @(posedge clk) disable iff (!rst_n) !check_rt || rt_data == exp_rt
   ) else begin
      $display("ERR %0t rt_data expected %h actual %h", $time, $sampled(exp_rt),
               $sampled(rt_data));
      rt_errors++;
   end

   // int and float reads of one address must not see the same word
   a_file_separation : assert property (
      @(posedge clk) disable iff (!rst_n) !check_sep || rs_data != rt_data
   ) else begin
      $display("at %0t rs_data and rt_data both read %h, the files are not kept apart",
               $time, $sampled(rs_data));
      sep_errors++;
   end

   function automatic int total_errors();
      return rs_errors + rt_errors + sep_errors;
   endfunction

   function automatic int retire_delay(input int port);
      if (port == P_MEM) begin
         return 1;
      end else if (port == P_FPU) begin
         return 0;
      end
      return 2;  // alu and misc pass both clocked stages
   endfunction

   function automatic logic [REG_DATA_W-1:0] fill_value(
      input logic                  fl,
      input logic [REG_ADDR_W-1:0] a
   );
      return {fl ? 8'hf1 : 8'h1e, 3'b000, a, 11'h000, a};
   endfunction

   task automatic clear_stage();
      int p;
      for (p = 0; p < 4; p++) begin
         st_en[p]   = 1'b0;
         st_addr[p] = '0;
         st_data[p] = '0;
         st_fl[p]   = 1'b0;
      end
      rd_valid = 1'b0;
      rd_sep   = 1'b0;
   endtask

   task automatic stage_write(input int port, input logic [REG_ADDR_W-1:0] a,
                              input logic [REG_DATA_W-1:0] d, input logic fl);
      st_en[port]   = 1'b1;
      st_addr[port] = a;
      st_data[port] = d;
      st_fl[port]   = fl;
   endtask

   task automatic stage_read(input logic [REG_ADDR_W-1:0] rsa, input logic rsf,
                             input logic [REG_ADDR_W-1:0] rta, input logic rtf,
                             input logic sep);
      rd_valid    = 1'b1;
      rd_sep      = sep;
      rd_rs_addr  = rsa;
      rd_rs_float = rsf;
      rd_rt_addr  = rta;
      rd_rt_float = rtf;
   endtask

   // present the staged cycle and predict last cycle's read
   task automatic run_cycle();
      int p;
      @(posedge clk);
      #1;
      cyc++;
      w_en     = st_en;
      w_addr   = st_addr;
      w_data   = st_data;
      w_fl     = st_fl;
      rs_addr  = rd_rs_addr;
      rt_addr  = rd_rt_addr;
      rs_float = rd_rs_float;
      rt_float = rd_rt_float;
      for (p = 0; p < 4; p++) begin
         if (st_en[p]) begin
            model[st_fl[p]][st_addr[p]]      = st_data[p];  // visible once presented
            busy_until[st_fl[p]][st_addr[p]] = cyc + retire_delay(p);
         end
      end
      check_rs  = prev_valid;
      check_rt  = prev_valid;
      check_sep = prev_valid && prev_sep;
      if (prev_valid) begin
         exp_rs = model[prev_rs_float][prev_rs_addr];
         exp_rt = model[prev_rt_float][prev_rt_addr];
         checks += prev_sep ? 3 : 2;
      end
      prev_valid    = rd_valid;
      prev_sep      = rd_sep;
      prev_rs_addr  = rd_rs_addr;
      prev_rs_float = rd_rs_float;
      prev_rt_addr  = rd_rt_addr;
      prev_rt_float = rd_rt_float;
      am_prev2      = am_prev;
      am_prev       = st_en[P_MISC] || st_en[P_ALU];
      mem_prev      = st_en[P_MEM];
      clear_stage();
   endtask

   task automatic close_test(input string name);
      run_cycle();
      run_cycle();
      $display("test %s finished, %0d errors", name, total_errors() - test_base);
      test_base = total_errors();
   endtask

   // random write on one port, skipped while that register has a write pending
   task automatic try_write(input int port);
      logic [31:0]           r;
      logic [REG_ADDR_W-1:0] a;
      logic                  fl;
      logic                  free;
      int                    q;
      r    = $random(seed);
      a    = r[REG_ADDR_W-1:0];
      fl   = r[8];
      free = (cyc + 1 > busy_until[fl][a]);
      for (q = 0; q < port; q++) begin
         if (st_en[q] && st_addr[q] == a && st_fl[q] == fl) begin
            free = 1'b0;
         end
      end
      if (free) begin
         stage_write(port, a, $random(seed), fl);
      end
   endtask

   initial begin
      int                    i;
      int                    p;
      logic [31:0]           r;
      logic [REG_ADDR_W-1:0] a;
      seed = 32'h39ec;
      rst_n = 1'b0;
      for (p = 0; p < 4; p++) begin
         w_en[p]   = 1'b0;
         w_addr[p] = '0;
         w_data[p] = '0;
         w_fl[p]   = 1'b0;
      end
      rs_addr  = '0;
      rt_addr  = '0;
      rs_float = 1'b0;
      rt_float = 1'b0;
      for (i = 0; i < 2 * NUM_REGS; i++) begin
         busy_until[i / NUM_REGS][i % NUM_REGS] = -1;
      end
      clear_stage();
      rd_rs_addr  = '0;
      rd_rt_addr  = '0;
      rd_rs_float = 1'b0;
      rd_rt_float = 1'b0;
      prev_valid  = 1'b0;
      prev_sep    = 1'b0;
      check_rs    = 1'b0;
      check_rt    = 1'b0;
      check_sep   = 1'b0;
      exp_rs      = '0;
      exp_rt      = '0;
      am_prev     = 1'b0;
      am_prev2    = 1'b0;
      mem_prev    = 1'b0;

      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n    = 1'b1;
      check_rs = 1'b1;  // read registers leave reset cleared
      check_rt = 1'b1;
      checks  += 2;

      // reset and fill, fpu writes retire at once
      for (i = 0; i < 2 * NUM_REGS; i++) begin
         stage_write(P_FPU, REG_ADDR_W'(i), fill_value(1'(i / NUM_REGS), REG_ADDR_W'(i)),
                     1'(i / NUM_REGS));
         run_cycle();
      end
      for (i = 0; i < NUM_REGS; i++) begin
         stage_read(REG_ADDR_W'(i), 1'b0, REG_ADDR_W'(i), 1'b1, 1'b1);
         run_cycle();
      end
      close_test("reset_and_fill");

      // queue bypass, read while the write sits in stage 2, 1 and 0
      for (p = P_ALU; p <= P_FPU; p++) begin
         a = REG_ADDR_W'(20 + p);
         stage_write(p, a, 32'hb0b0_0000 + p, 1'(p));
         for (i = 0; i < 3; i++) begin
            stage_read(a, 1'(p), a, !1'(p), 1'b0);
            run_cycle();
         end
         run_cycle();
      end
      close_test("queue_bypass");

      // same-cycle forwarding, write arrives the cycle after the read
      for (p = P_MISC; p <= P_FPU; p++) begin
         a = REG_ADDR_W'(24 + p);
         stage_read(a, p == P_FPU, a, p == P_FPU, 1'b0);
         run_cycle();
         stage_write(p, a, 32'hc0de_0000 + p, p == P_FPU);
         run_cycle();
         repeat (3) run_cycle();
      end
      close_test("same_cycle_forwarding");

      // int and float writes to one address
      for (i = 0; i < 2; i++) begin
         a = REG_ADDR_W'(9 + i);
         if (i == 0) begin
            stage_write(P_ALU, a, 32'h1111_0009, 1'b0);
            stage_write(P_MEM, a, 32'hf10a_0009, 1'b1);
         end else begin
            stage_write(P_MISC, a, 32'h2222_000a, 1'b0);
            stage_write(P_FPU, a, 32'hf20b_000a, 1'b1);
         end
         for (p = 0; p < 4; p++) begin
            stage_read(a, i == 1, a, i == 0, 1'b1);
            run_cycle();
         end
      end
      close_test("file_separation");

      // random legal traffic on all ports
      for (i = 0; i < RANDOM_CYCLES; i++) begin
         r = $random(seed);
         if (r[1:0] == 2'd1) begin
            try_write(P_MISC);
         end else if (r[1:0] == 2'd2) begin
            try_write(P_ALU);
         end
         if (r[2] && !am_prev) begin
            try_write(P_MEM);
         end
         if (r[3] && !mem_prev && !am_prev2) begin
            try_write(P_FPU);
         end
         stage_read(r[8:4], r[9], r[14:10], r[15], 1'b0);
         run_cycle();
      end
      close_test("random_traffic");

      $display("checks %0d, errors %0d", checks, total_errors());
      if (total_errors() == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule
